/* flist.f */
+incdir+source
source/ucodePkg.sv
source/opcodeFlowLut.sv
source/cbFlowLut.sv
source/ucodeRom.sv
source/ucodeFrontEnd.sv
tb/ucodeChecker.sv
tb/ucodeTb.sv

/* run.sh */
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module ucodeTb -Mdir obj_dir
if [ $? -ne 0 ]; then
	echo "Verilator build failed"
	exit 1
fi

output=$(./obj_dir/VucodeTb)
status=$?
echo "$output"
if [ $status -ne 0 ]; then
	echo "Simulation exited with status $status"
	exit 1
fi

if echo "$output" | grep -qx "Result: PASSED"; then
	exit 0
fi
echo "Pass message not found in simulation output"
exit 1

/* tb/ucodeTb.sv */
`timescale 1ns/1ns
`include "ucodeCfg_cfg.svh"

module ucodeTb;
	import ucodePkg::*;

	localparam int resetTimeout = 40;
	localparam int phaseTimeout = 20;

	logic clock;
	logic rst;
	logic [`UCODE_OPCODE_W-1:0] opcode;
	logic cbPrefix;
	logic [`UCODE_ADDR_W-1:0] uopAddr;
	logic [`UCODE_ADDR_W-1:0] flowIdx;
	flowCtlE uopFlow;
	uopActE uopAct;
	uopOperandE uopOperand;
	int phase;
	int seq;
	int issued;
	int errCount;
	int seqChecked;
	int timeoutCount;
	logic [31:0] rngState;

	ucodeFrontEnd dut_i (
		.clock(clock),
		.rst(rst),
		.opcode(opcode),
		.cbPrefix(cbPrefix),
		.uopAddr(uopAddr),
		.flowIdx(flowIdx),
		.uopFlow(uopFlow),
		.uopAct(uopAct),
		.uopOperand(uopOperand)
	);

	ucodeChecker check_i (.*);

	initial
		clock = 1'b0;

	always #50 clock = ~clock;

	initial
	begin
		rst = 1'b1;
		repeat (8) @(posedge clock);
		rst <= 1'b0;
	end

	function automatic logic [31:0] xorshift(input logic [31:0] s);
		logic [31:0] x;
		x = s;
		x ^= x << 13;
		x ^= x >> 17;
		x ^= x << 5;
		return x;
	endfunction

	// One item per clock on both read paths
	task automatic driveItem(input int ph, input logic [7:0] opc, input logic cb,
		input logic [`UCODE_ADDR_W-1:0] addr);
		@(posedge clock);
		issued++;
		phase <= ph;
		opcode <= opc;
		cbPrefix <= cb;
		uopAddr <= addr;
		seq <= issued;
	endtask

	// Reset counts as active until it reads a clean low
	task automatic waitResetDone();
		int cycles;
		cycles = 0;
		while (rst !== 1'b0 && cycles < resetTimeout)
		begin
			@(posedge clock);
			cycles++;
		end
		if (rst !== 1'b0)
		begin
			timeoutCount++;
			$display("Timeout: reset was never released");
		end
	endtask

	task automatic waitChecked(input string what);
		int cycles;
		cycles = 0;
		while (seqChecked != issued && cycles < phaseTimeout)
		begin
			@(posedge clock);
			cycles++;
		end
		if (seqChecked != issued)
		begin
			timeoutCount++;
			$display("Timeout: checker never reached the last item of %s", what);
		end
	endtask

	//////////////////////////////////////////////////
	// Stimulus phases
	//////////////////////////////////////////////////

	initial
	begin
		opcode = '0;
		cbPrefix = 1'b0;
		uopAddr = '0;
		phase = 0;
		seq = 0;
		issued = 0;
		timeoutCount = 0;
		rngState = 32'd96;
		waitResetDone();

		for (int i = 0; i < 256; i++)
			driveItem(1, 8'(i), 1'b0, `UCODE_ADDR_W'(i));
		waitChecked("mainTable");

		for (int i = 0; i < 200; i++)
		begin
			rngState = xorshift(rngState);
			driveItem(2, rngState[7:0], 1'b0, rngState[17:8]);
		end
		waitChecked("mainRandom");

		for (int i = 0; i < 256; i++)
			driveItem(3, 8'(i), 1'b1, `UCODE_ADDR_W'(i + 256));
		waitChecked("cbTable");

		// Whole address space, including the words past the ROM depth
		for (int i = 0; i < (1 << `UCODE_ADDR_W); i++)
		begin
			rngState = xorshift(rngState);
			driveItem(4, rngState[7:0], rngState[8], `UCODE_ADDR_W'(i));
		end
		waitChecked("romSweep");

		for (int i = 0; i < 300; i++)
		begin
			rngState = xorshift(rngState);
			driveItem(5, rngState[7:0], rngState[20], rngState[17:8]);
		end
		waitChecked("backToBack");

		$display("Errors: mismatches=%0d timeouts=%0d", errCount, timeoutCount);
		if (errCount == 0 && timeoutCount == 0)
			$display("Result: PASSED");
		else
			$display("Result: FAILED");
		$finish;
	end

endmodule

/* tb/ucodeChecker.sv */
`timescale 1ns/1ns
`include "ucodeCfg_cfg.svh"

module ucodeChecker
(
	input logic clock,
	input logic rst,
	input logic [`UCODE_OPCODE_W-1:0] opcode,
	input logic cbPrefix,
	input logic [`UCODE_ADDR_W-1:0] uopAddr,
	input int phase,
	input int seq,
	input logic [`UCODE_ADDR_W-1:0] flowIdx,
	input ucodePkg::flowCtlE uopFlow,
	input ucodePkg::uopActE uopAct,
	input ucodePkg::uopOperandE uopOperand,
	output int errCount,
	output int seqChecked
);
	import ucodePkg::*;

	// Flow starts per register code b, c, d, e, h, l, (hl), a
	localparam int ldFlow [0:7] = '{60, 23, 136, 121, 146, 112, 0, 26};
	localparam int incFlow [0:7] = '{161, 32, 164, 250, 312, 308, 0, 302};
	localparam int decFlow [0:7] = '{300, 48, 135, 166, 170, 310, 0, 47};
	localparam int addFlow [0:7] = '{178, 184, 187, 190, 193, 196, 0, 175};
	localparam int subFlow [0:7] = '{132, 181, 199, 202, 205, 208, 0, 211};

	logic [14:0] refRom [0:(1 << `UCODE_ADDR_W)-1];
	logic primed = 1'b0;
	logic prevRst;
	logic [`UCODE_OPCODE_W-1:0] prevOpcode;
	logic prevCb;
	logic [`UCODE_ADDR_W-1:0] prevAddr;
	int prevPhase;
	int prevSeq;
	int errTotal = 0;
	int lastChecked = 0;

	assign errCount = errTotal;
	assign seqChecked = lastChecked;

	function automatic string phaseName(input int p);
		case (p)
			0: return "reset";
			1: return "mainTable";
			2: return "mainRandom";
			3: return "cbTable";
			4: return "romSweep";
			5: return "backToBack";
			default: return "idle";
		endcase
	endfunction

	function automatic uopOperandE regOperand(input int code);
		case (code)
			0: return b;
			1: return c;
			2: return d;
			3: return e;
			4: return h;
			5: return l;
			7: return a;
			default: return none;
		endcase
	endfunction

	//////////////////////////////////////////////////
	// Expected flow index
	//////////////////////////////////////////////////

	function automatic logic [`UCODE_ADDR_W-1:0] flowRef(input logic [7:0] opc, input logic cb);
		logic [`UCODE_ADDR_W-1:0] idx;
		idx = `UCODE_ADDR_W'(`UCODE_FLOW_DEFAULT);
		if (cb)
		begin
			case (opc)
				8'h7C: idx = 10'd16;
				8'h11: idx = 10'd69;
				8'h38: idx = 10'd505;
				8'h18, 8'h19, 8'h1A, 8'h1B, 8'h1C, 8'h1D, 8'h1F: idx = 10'd509;
				default: idx = `UCODE_ADDR_W'(`UCODE_FLOW_CB_NONE);
			endcase
		end
		else
		begin
			case (opc)
				8'h00: idx = 10'd162;
				8'h76: idx = 10'd547;
				8'hF3: idx = 10'd163;
				8'hFB: idx = 10'd511;
				8'hC1: idx = 10'd71;
				8'hC5: idx = 10'd63;
				8'hD1: idx = 10'd226;
				8'hD5: idx = 10'd214;
				8'h18: idx = 10'd115;
				8'h20: idx = 10'd17;
				8'h28: idx = 10'd106;
				8'h30: idx = 10'd414;
				default:
				begin
					// Register code 6 is (hl), which has no flow of its own here
					if (opc[7:6] == 2'b00 && opc[5:3] != 3'd6 && opc[2:0] == 3'd6)
						idx = `UCODE_ADDR_W'(ldFlow[opc[5:3]]);
					else if (opc[7:6] == 2'b00 && opc[5:3] != 3'd6 && opc[2:0] == 3'd4)
						idx = `UCODE_ADDR_W'(incFlow[opc[5:3]]);
					else if (opc[7:6] == 2'b00 && opc[5:3] != 3'd6 && opc[2:0] == 3'd5)
						idx = `UCODE_ADDR_W'(decFlow[opc[5:3]]);
					else if (opc[7:3] == 5'b10000 && opc[2:0] != 3'd6)
						idx = `UCODE_ADDR_W'(addFlow[opc[2:0]]);
					else if (opc[7:3] == 5'b10010 && opc[2:0] != 3'd6)
						idx = `UCODE_ADDR_W'(subFlow[opc[2:0]]);
				end
			endcase
		end
		return idx;
	endfunction

	function automatic logic [14:0] uopRef(input logic [`UCODE_ADDR_W-1:0] addr);
		logic [14:0] word;
		word = {op, nop, none};
		if (int'(addr) < `UCODE_ROM_DEPTH)
			word = refRom[addr];
		return word;
	endfunction

	//////////////////////////////////////////////////
	// Expected ROM, built flow by flow
	//////////////////////////////////////////////////

	task automatic putWord(input int addr, input flowCtlE fc, input uopActE act,
		input uopOperandE opnd);
		refRom[addr] = {fc, act, opnd};
	endtask

	// Fetch the immediate, then store it
	task automatic putLoad(input int s, input uopOperandE r);
		putWord(s, inc, sma, pc);
		putWord(s + 1, inc, nop, none);
		putWord(s + 2, eof, srm, r);
	endtask

	task automatic putIncDec(input int s, input uopActE act, input uopOperandE r);
		if (s inside {32, 161, 47, 48, 135})
			putWord(s, incEofFu, act, r);
		else
		begin
			putWord(s, updateFlags, act, r);
			putWord(s + 1, incEof, nop, none);
		end
	endtask

	task automatic putAlu(input int s, input uopActE act, input uopOperandE r);
		putWord(s, op, sx16r, a);
		putWord(s + 1, updateFlags, act, r);
		putWord(s + 2, incEof, srx16, a);
	endtask

	// Word s+1 stays a plain nop
	task automatic putJr(input int s, input flowCtlE fc);
		putWord(s, inc, sma, pc);
		putWord(s + 2, fc, srm, x8);
		putWord(s + 3, op, sx16r, pc);
		putWord(s + 4, op, addx16, x8);
		putWord(s + 5, eof, spc, x16);
	endtask

	task automatic putPush(input int s, input uopOperandE hi, input uopOperandE lo);
		putWord(s, op, dec16, sp);
		putWord(s + 2, op, smw, hi);
		putWord(s + 3, op, dec16, sp);
		putWord(s + 4, op, smw, lo);
		putWord(s + 5, incEof, sma, pc);
	endtask

	task automatic putPop(input int s, input uopOperandE lo, input uopOperandE hi);
		putWord(s, op, sma, sp);
		putWord(s + 1, op, inc16, sp);
		putWord(s + 2, op, srm, lo);
		putWord(s + 3, op, srm, hi);
		putWord(s + 4, inc, inc16, sp);
		putWord(s + 5, eof, sma, pc);
	endtask

	initial
	begin
		for (int i = 0; i < (1 << `UCODE_ADDR_W); i++)
			refRom[i] = {op, nop, none};
		for (int r = 0; r < 8; r++)
		begin
			if (r != 6)
			begin
				putLoad(ldFlow[r], regOperand(r));
				putIncDec(incFlow[r], inc16, regOperand(r));
				putIncDec(decFlow[r], dec16, regOperand(r));
				putAlu(addFlow[r], addx16u, regOperand(r));
				putAlu(subFlow[r], subx16, regOperand(r));
			end
		end
		putWord(0, incEofFu, z801bop, a);
		putWord(278, updateFlags, z801bop, a);
		putWord(279, incEof, nop, none);
		putWord(162, incEof, nop, none);
		putWord(163, incEof, ceti, none);
		putWord(511, incEof, seti, none);
		putWord(547, op, hlt, none);
		putWord(548, incEof, nop, none);
		putJr(115, inc);
		putJr(106, incEofNz);
		putJr(17, incEofZ);
		// JR NC has its own layout
		putWord(414, inc, sma, pc);
		putWord(415, incEofC, sx16r, pc);
		putWord(416, op, addx16, x8);
		putWord(417, op, inc16, x16);
		putWord(418, op, spc, x16);
		putWord(419, eof, nop, none);
		putPush(63, b, c);
		putWord(64, op, sma, sp);
		putPush(214, d, e);
		putPop(71, c, b);
		putPop(226, e, d);
		putWord(16, eofFu, bitTest, none);
		putWord(69, eofFu, shl, none);
		putWord(505, updateFlags, shr, none);
		putWord(506, eof, nop, none);
		putWord(509, updateFlags, rrot, none);
		putWord(510, eof, nop, none);
	end

	//////////////////////////////////////////////////
	// Compare one cycle after each input
	//////////////////////////////////////////////////

	always @(posedge clock)
	begin
		primed <= 1'b1;
		prevRst <= rst;
		prevOpcode <= opcode;
		prevCb <= cbPrefix;
		prevAddr <= uopAddr;
		prevPhase <= phase;
		prevSeq <= seq;
	end

	// Outputs settle well before the falling edge
	always @(negedge clock)
	begin
		logic [`UCODE_ADDR_W-1:0] expIdx;
		logic [14:0] expUop;
		if (primed)
		begin
			if (prevRst)
			begin
				expIdx = '0;
				expUop = {op, nop, none};
			end
			else
			begin
				expIdx = flowRef(prevOpcode, prevCb);
				expUop = uopRef(prevAddr);
			end
			if (flowIdx !== expIdx)
			begin
				errTotal++;
				$display("ERR %s flowIdx opcode %h cb %0d: expected %0d actual %0d",
					phaseName(prevPhase), prevOpcode, prevCb, expIdx, flowIdx);
			end
			if ({uopFlow, uopAct, uopOperand} !== expUop)
			begin
				errTotal++;
				$display("ERR %s uop addr %0d: expected %h actual %h",
					phaseName(prevPhase), prevAddr, expUop, {uopFlow, uopAct, uopOperand});
			end
			lastChecked = prevSeq;
		end
	end

endmodule

/* source/ucodeFrontEnd.sv */
`timescale 1ns/1ns
`include "ucodeCfg_cfg.svh"

module ucodeFrontEnd
(
	input logic clock,
	input logic rst,
	input logic [`UCODE_OPCODE_W-1:0] opcode,
	input logic cbPrefix,
	input logic [`UCODE_ADDR_W-1:0] uopAddr,
	output logic [`UCODE_ADDR_W-1:0] flowIdx,
	output ucodePkg::flowCtlE uopFlow,
	output ucodePkg::uopActE uopAct,
	output ucodePkg::uopOperandE uopOperand
);

	logic [`UCODE_ADDR_W-1:0] mainIdx;
	logic [`UCODE_CB_IDX_W-1:0] cbIdx;
	logic [`UCODE_ADDR_W-1:0] selIdx;

	//////////////////////////////////////////////////
	// Flow index lookup
	//////////////////////////////////////////////////

	opcodeFlowLut mainLut_i (.opcode(opcode), .mainIdx(mainIdx));

	cbFlowLut cbLut_i (.opcode(opcode), .cbIdx(cbIdx));

	// CB table is one bit narrower
	assign selIdx = cbPrefix ? `UCODE_ADDR_W'(cbIdx) : mainIdx;

	always_ff @(posedge clock)
	begin
		if (rst)
			flowIdx <= '0;
		else
			flowIdx <= selIdx;
	end

	//////////////////////////////////////////////////
	// Microcode read
	//////////////////////////////////////////////////

	ucodeRom rom_i (
		.clock(clock),
		.rst(rst),
		.uopAddr(uopAddr),
		.uopFlow(uopFlow),
		.uopAct(uopAct),
		.uopOperand(uopOperand)
	);

	// Whichever table was picked, the index must land inside the ROM
	flowIdxInRom: assert property (@(posedge clock) disable iff (rst)
		flowIdx < `UCODE_ROM_DEPTH)
	else
		$error("ucodeFrontEnd: flow index %0d beyond ROM", flowIdx);

endmodule

/* source/ucodeRom.sv */
`timescale 1ns/1ns
`include "ucodeCfg_cfg.svh"

module ucodeRom
(
	input logic clock,
	input logic rst,
	input logic [`UCODE_ADDR_W-1:0] uopAddr,
	output ucodePkg::flowCtlE uopFlow,
	output ucodePkg::uopActE uopAct,
	output ucodePkg::uopOperandE uopOperand
);
	import ucodePkg::*;

	flowCtlE romFlow;
	uopActE romAct;
	uopOperandE romOperand;

	//////////////////////////////////////////////////
	// Word decode
	//////////////////////////////////////////////////

	// Words that are op, nop, none inside a flow are left to the default
	always_comb
	begin
		romFlow = op;
		romAct = nop;
		romOperand = none;
		case (uopAddr)
			0: {romFlow, romAct, romOperand} = {incEofFu, z801bop, a};
			278: {romFlow, romAct, romOperand} = {updateFlags, z801bop, a};
			// Operand fetch, shared by immediate loads and jumps
			17, 23, 26, 60, 106, 112, 115, 121, 136, 146, 414:
				{romFlow, romAct, romOperand} = {inc, sma, pc};
			24, 27, 61, 113, 122, 137, 147:
				{romFlow, romAct, romOperand} = {inc, nop, none};
			25: {romFlow, romAct, romOperand} = {eof, srm, c};
			28: {romFlow, romAct, romOperand} = {eof, srm, a};
			62: {romFlow, romAct, romOperand} = {eof, srm, b};
			114: {romFlow, romAct, romOperand} = {eof, srm, l};
			123: {romFlow, romAct, romOperand} = {eof, srm, e};
			138: {romFlow, romAct, romOperand} = {eof, srm, d};
			148: {romFlow, romAct, romOperand} = {eof, srm, h};
			// Relative jumps, the conditional ones leave early
			19: {romFlow, romAct, romOperand} = {incEofZ, srm, x8};
			108: {romFlow, romAct, romOperand} = {incEofNz, srm, x8};
			117: {romFlow, romAct, romOperand} = {inc, srm, x8};
			415: {romFlow, romAct, romOperand} = {incEofC, sx16r, pc};
			20, 109, 118: {romFlow, romAct, romOperand} = {op, sx16r, pc};
			21, 110, 119, 416: {romFlow, romAct, romOperand} = {op, addx16, x8};
			22, 111, 120: {romFlow, romAct, romOperand} = {eof, spc, x16};
			417: {romFlow, romAct, romOperand} = {op, inc16, x16};
			418: {romFlow, romAct, romOperand} = {op, spc, x16};
			// Single word inc/dec
			32: {romFlow, romAct, romOperand} = {incEofFu, inc16, c};
			161: {romFlow, romAct, romOperand} = {incEofFu, inc16, b};
			47: {romFlow, romAct, romOperand} = {incEofFu, dec16, a};
			48: {romFlow, romAct, romOperand} = {incEofFu, dec16, c};
			135: {romFlow, romAct, romOperand} = {incEofFu, dec16, d};
			// Two word inc/dec, flags then close
			164: {romFlow, romAct, romOperand} = {updateFlags, inc16, d};
			250: {romFlow, romAct, romOperand} = {updateFlags, inc16, e};
			302: {romFlow, romAct, romOperand} = {updateFlags, inc16, a};
			308: {romFlow, romAct, romOperand} = {updateFlags, inc16, l};
			312: {romFlow, romAct, romOperand} = {updateFlags, inc16, h};
			166: {romFlow, romAct, romOperand} = {updateFlags, dec16, e};
			170: {romFlow, romAct, romOperand} = {updateFlags, dec16, h};
			300: {romFlow, romAct, romOperand} = {updateFlags, dec16, b};
			310: {romFlow, romAct, romOperand} = {updateFlags, dec16, l};
			162, 165, 167, 171, 251, 279, 301, 303, 309, 311, 313, 548:
				{romFlow, romAct, romOperand} = {incEof, nop, none};
			// Push and pop
			63, 66, 214, 217: {romFlow, romAct, romOperand} = {op, dec16, sp};
			64, 71, 226: {romFlow, romAct, romOperand} = {op, sma, sp};
			65: {romFlow, romAct, romOperand} = {op, smw, b};
			67: {romFlow, romAct, romOperand} = {op, smw, c};
			216: {romFlow, romAct, romOperand} = {op, smw, d};
			218: {romFlow, romAct, romOperand} = {op, smw, e};
			68, 219: {romFlow, romAct, romOperand} = {incEof, sma, pc};
			72, 227: {romFlow, romAct, romOperand} = {op, inc16, sp};
			73: {romFlow, romAct, romOperand} = {op, srm, c};
			74: {romFlow, romAct, romOperand} = {op, srm, b};
			228: {romFlow, romAct, romOperand} = {op, srm, e};
			229: {romFlow, romAct, romOperand} = {op, srm, d};
			75, 230: {romFlow, romAct, romOperand} = {inc, inc16, sp};
			76, 231: {romFlow, romAct, romOperand} = {eof, sma, pc};
			// A goes through x16 for ADD and SUB
			132, 175, 178, 181, 184, 187, 190, 193, 196, 199, 202, 205, 208, 211:
				{romFlow, romAct, romOperand} = {op, sx16r, a};
			176: {romFlow, romAct, romOperand} = {updateFlags, addx16u, a};
			179: {romFlow, romAct, romOperand} = {updateFlags, addx16u, b};
			185: {romFlow, romAct, romOperand} = {updateFlags, addx16u, c};
			188: {romFlow, romAct, romOperand} = {updateFlags, addx16u, d};
			191: {romFlow, romAct, romOperand} = {updateFlags, addx16u, e};
			194: {romFlow, romAct, romOperand} = {updateFlags, addx16u, h};
			197: {romFlow, romAct, romOperand} = {updateFlags, addx16u, l};
			133: {romFlow, romAct, romOperand} = {updateFlags, subx16, b};
			182: {romFlow, romAct, romOperand} = {updateFlags, subx16, c};
			200: {romFlow, romAct, romOperand} = {updateFlags, subx16, d};
			203: {romFlow, romAct, romOperand} = {updateFlags, subx16, e};
			206: {romFlow, romAct, romOperand} = {updateFlags, subx16, h};
			209: {romFlow, romAct, romOperand} = {updateFlags, subx16, l};
			212: {romFlow, romAct, romOperand} = {updateFlags, subx16, a};
			134, 177, 180, 183, 186, 189, 192, 195, 198, 201, 204, 207, 210, 213:
				{romFlow, romAct, romOperand} = {incEof, srx16, a};
			// CB flows
			16: {romFlow, romAct, romOperand} = {eofFu, bitTest, none};
			69: {romFlow, romAct, romOperand} = {eofFu, shl, none};
			505: {romFlow, romAct, romOperand} = {updateFlags, shr, none};
			509: {romFlow, romAct, romOperand} = {updateFlags, rrot, none};
			419, 506, 510: {romFlow, romAct, romOperand} = {eof, nop, none};
			// Interrupt enable and halt
			163: {romFlow, romAct, romOperand} = {incEof, ceti, none};
			511: {romFlow, romAct, romOperand} = {incEof, seti, none};
			547: {romFlow, romAct, romOperand} = {op, hlt, none};
			default: ;
		endcase
	end

	// Block ROM style output register
	always_ff @(posedge clock)
	begin
		if (rst)
		begin
			uopFlow <= op;
			uopAct <= nop;
			uopOperand <= none;
		end
		else
		begin
			uopFlow <= romFlow;
			uopAct <= romAct;
			uopOperand <= romOperand;
		end
	end

endmodule

/* source/cbFlowLut.sv */
`timescale 1ns/1ns
`include "ucodeCfg_cfg.svh"

module cbFlowLut
(
	input logic [`UCODE_OPCODE_W-1:0] opcode,
	output logic [`UCODE_CB_IDX_W-1:0] cbIdx
);

	always_comb
	begin
		case (opcode)
			8'h7C: cbIdx = `UCODE_CB_IDX_W'(`UCODE_FLOW_CB_BIT7);
			8'h11: cbIdx = `UCODE_CB_IDX_W'(`UCODE_FLOW_CB_RL);
			8'h38: cbIdx = `UCODE_CB_IDX_W'(`UCODE_FLOW_CB_SRL);
			// RR b, c, d, e, h, l and a
			8'h18, 8'h19, 8'h1A, 8'h1B, 8'h1C, 8'h1D, 8'h1F:
				cbIdx = `UCODE_CB_IDX_W'(`UCODE_FLOW_CB_RR);
			default: cbIdx = `UCODE_CB_IDX_W'(`UCODE_FLOW_CB_NONE);
		endcase
	end

endmodule

/* source/opcodeFlowLut.sv */
`timescale 1ns/1ns
`include "ucodeCfg_cfg.svh"

module opcodeFlowLut
(
	input logic [`UCODE_OPCODE_W-1:0] opcode,
	output logic [`UCODE_ADDR_W-1:0] mainIdx
);
	import ucodePkg::*;

	always_comb
	begin
		case (opcodeE'(opcode))
			// Control and misc
			NOP: mainIdx = 10'd162;
			DI: mainIdx = 10'd163;
			EI: mainIdx = 10'd511;
			HALT: mainIdx = 10'd547;
			// Immediate loads
			LDrn_b: mainIdx = 10'd60;
			LDrn_c: mainIdx = 10'd23;
			LDrn_d: mainIdx = 10'd136;
			LDrn_e: mainIdx = 10'd121;
			LDrn_h: mainIdx = 10'd146;
			LDrn_l: mainIdx = 10'd112;
			LDrn_a: mainIdx = 10'd26;
			// 8-bit increment and decrement
			INCr_b: mainIdx = 10'd161;
			INCr_c: mainIdx = 10'd32;
			INCr_d: mainIdx = 10'd164;
			INCr_e: mainIdx = 10'd250;
			INCr_h: mainIdx = 10'd312;
			INCr_l: mainIdx = 10'd308;
			INCr_a: mainIdx = 10'd302;
			DECr_b: mainIdx = 10'd300;
			DECr_c: mainIdx = 10'd48;
			DECr_d: mainIdx = 10'd135;
			DECr_e: mainIdx = 10'd166;
			DECr_h: mainIdx = 10'd170;
			DECr_l: mainIdx = 10'd310;
			DECr_a: mainIdx = 10'd47;
			// Accumulator arithmetic
			ADDr_b: mainIdx = 10'd178;
			ADDr_c: mainIdx = 10'd184;
			ADDr_d: mainIdx = 10'd187;
			ADDr_e: mainIdx = 10'd190;
			ADDr_h: mainIdx = 10'd193;
			ADDr_l: mainIdx = 10'd196;
			ADDr_a: mainIdx = 10'd175;
			SUBr_b: mainIdx = 10'd132;
			SUBr_c: mainIdx = 10'd181;
			SUBr_d: mainIdx = 10'd199;
			SUBr_e: mainIdx = 10'd202;
			SUBr_h: mainIdx = 10'd205;
			SUBr_l: mainIdx = 10'd208;
			SUBr_a: mainIdx = 10'd211;
			// Stack
			PUSHBC: mainIdx = 10'd63;
			POPBC: mainIdx = 10'd71;
			PUSHDE: mainIdx = 10'd214;
			POPDE: mainIdx = 10'd226;
			// Relative jumps
			JRn: mainIdx = 10'd115;
			JRZn: mainIdx = 10'd106;
			JRNZn: mainIdx = 10'd17;
			JRNCn: mainIdx = 10'd414;
			// Generic 1 byte flow
			default: mainIdx = `UCODE_ADDR_W'(`UCODE_FLOW_DEFAULT);
		endcase
	end

endmodule

/* source/ucodePkg.sv */
`include "ucodeCfg_cfg.svh"

package ucodePkg;

	//////////////////////////////////////////////////
	// Micro-op fields
	//////////////////////////////////////////////////

	// Sequencer control, what happens to the uPC after this word
	typedef enum logic [3:0] {
		op,
		inc,
		eof,
		incEof,
		eofFu,
		incEofFu,
		updateFlags,
		incEofZ,
		incEofNz,
		incEofC
	} flowCtlE;

	typedef enum logic [5:0] {
		nop,
		sma,
		smw,
		srm,
		inc16,
		dec16,
		sx16r,
		srx16,
		addx16,
		addx16u,
		subx16,
		spc,
		jcb,
		bitTest,
		shl,
		shr,
		rrot,
		seti,
		ceti,
		hlt,
		z801bop
	} uopActE;

	// Register or temp the action works on
	typedef enum logic [4:0] {
		none,
		a,
		b,
		c,
		d,
		e,
		h,
		l,
		f,
		bc,
		de,
		hl,
		sp,
		pc,
		x8,
		x16
	} uopOperandE;

	//////////////////////////////////////////////////
	// Main opcodes with a flow of their own
	//////////////////////////////////////////////////

	typedef enum logic [`UCODE_OPCODE_W-1:0] {
		NOP = 8'h00, HALT = 8'h76, DI = 8'hF3, EI = 8'hFB,
		LDrn_b = 8'h06, LDrn_c = 8'h0E, LDrn_d = 8'h16, LDrn_e = 8'h1E,
		LDrn_h = 8'h26, LDrn_l = 8'h2E, LDrn_a = 8'h3E,
		INCr_b = 8'h04, INCr_c = 8'h0C, INCr_d = 8'h14, INCr_e = 8'h1C,
		INCr_h = 8'h24, INCr_l = 8'h2C, INCr_a = 8'h3C,
		DECr_b = 8'h05, DECr_c = 8'h0D, DECr_d = 8'h15, DECr_e = 8'h1D,
		DECr_h = 8'h25, DECr_l = 8'h2D, DECr_a = 8'h3D,
		ADDr_b = 8'h80, ADDr_c = 8'h81, ADDr_d = 8'h82, ADDr_e = 8'h83,
		ADDr_h = 8'h84, ADDr_l = 8'h85, ADDr_a = 8'h87,
		SUBr_b = 8'h90, SUBr_c = 8'h91, SUBr_d = 8'h92, SUBr_e = 8'h93,
		SUBr_h = 8'h94, SUBr_l = 8'h95, SUBr_a = 8'h97,
		POPBC = 8'hC1, PUSHBC = 8'hC5, POPDE = 8'hD1, PUSHDE = 8'hD5,
		JRn = 8'h18, JRNZn = 8'h20, JRZn = 8'h28, JRNCn = 8'h30
	} opcodeE;

endpackage

/* source/ucodeCfg_cfg.svh */
`ifndef UCODE_CFG_SVH
`define UCODE_CFG_SVH

// Table and ROM widths
`define UCODE_OPCODE_W 8
`define UCODE_ADDR_W 10
`define UCODE_CB_IDX_W 9

// Addressable microcode words
`define UCODE_ROM_DEPTH 587

// Fixed flow indices
`define UCODE_FLOW_DEFAULT 278
`define UCODE_FLOW_CB_NONE 0
`define UCODE_FLOW_CB_BIT7 16
`define UCODE_FLOW_CB_RL 69
`define UCODE_FLOW_CB_SRL 505
`define UCODE_FLOW_CB_RR 509

`endif
